// File: ni_rx.f
hdl/noc_rx_pkg.sv
hdl/flit_fifo.sv
hdl/flit_deserializer.sv
hdl/word_arbiter.sv
hdl/ni_rx.sv
dv/ni_rx_tb.sv

// File: Bender.yml
package:
  name: ni_rx

dependencies: {}

sources:
  # shared package first, then leaf modules, then the top level
  - hdl/noc_rx_pkg.sv
  - hdl/flit_fifo.sv
  - hdl/flit_deserializer.sv
  - hdl/word_arbiter.sv
  - hdl/ni_rx.sv

  # testbench
  - target: test
    files:
      - dv/ni_rx_tb.sv

// File: dv/ni_rx_tb.sv
`timescale 1ns/1ps

// testbench for ni_rx with two link drivers, random core acknowledge and a per-link scoreboard
module ni_rx_tb import noc_rx_pkg::*; ();

	localparam int MAX_ROWS = 8;

	// one packet of the stimulus table
	typedef struct packed {
		link_id_t                         link;
		logic [1:0]                       groups; // 1 to 3
		logic [FLIT_PAYLOAD_W-1:0]        route;  // header flit payload, must never reach the core
		logic [2:0][3*FLIT_PAYLOAD_W-1:0] pay;    // 30-bit payload per group
	} pkt_row_t;

	logic      clk;
	logic      reset;
	flit_t     north_flit;
	flit_t     east_flit;
	logic      north_push;
	logic      east_push;
	logic      north_full;
	logic      east_full;
	core_msg_t core_msg;
	logic      core_valid;
	logic      core_ack;

	pkt_row_t   pkt_table [MAX_ROWS];
	int         num_rows      = 0;
	int         total_flits   = 0;
	int         cycle_limit   = 0;
	int         cycle_count   = 0;
	int         groups_pushed = 0; // complete groups written into the buffers
	int         acks_done     = 0;
	integer     seed          = 32'h3b108b29;
	core_word_t north_exp [$];     // expected words per link, in push order
	core_word_t east_exp [$];
	logic       saw_north_full = 1'b0;
	logic       saw_east_full  = 1'b0;
	logic       have_held      = 1'b0;

	ni_rx ni_rx_i (
		.clk        (clk),
		.reset      (reset),
		.north_flit (north_flit),
		.east_flit  (east_flit),
		.north_push (north_push),
		.east_push  (east_push),
		.north_full (north_full),
		.east_full  (east_full),
		.core_msg   (core_msg),
		.core_valid (core_valid),
		.core_ack   (core_ack)
	);

	always #10 clk = ~clk; // 20 ns period

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR @%0t: %s, got %h expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	// table row plus its expected words, top two bits of each word are zero
	task automatic add_packet(input link_id_t link, input int groups, input logic [9:0] route,
	                          input logic [29:0] p0, input logic [29:0] p1, input logic [29:0] p2);
		pkt_row_t row;
		row.link   = link;
		row.groups = groups[1:0];
		row.route  = route;
		row.pay    = {p2, p1, p0};
		pkt_table[num_rows] = row;
		num_rows++;
		total_flits += 1 + 3 * groups; // header + three per group
		for (int g = 0; g < groups; g++) begin
			if (link == link_north) north_exp.push_back(core_word_t'({2'b00, row.pay[g]}));
			else                    east_exp.push_back(core_word_t'({2'b00, row.pay[g]}));
		end
	endtask

	// called 2 ns after a rising edge, returns 2 ns after the push edge
	task automatic push_flit(input link_id_t link, input flit_t f);
		logic busy;
		busy = (link == link_north) ? north_full : east_full;
		while (busy) begin // no credits, so the link just waits out full
			@(posedge clk);
			#2;
			busy = (link == link_north) ? north_full : east_full;
		end
		if (link == link_north) begin
			north_flit = f;
			north_push = 1'b1;
		end else begin
			east_flit = f;
			east_push = 1'b1;
		end
		@(posedge clk);
		#2;
		if (link == link_north) north_push = 1'b0;
		else                    east_push  = 1'b0;
	endtask

	// walks the whole table, sends only the rows of its own link
	task automatic drive_link(input link_id_t link);
		flit_t f;
		for (int r = 0; r < num_rows; r++) begin
			if (pkt_table[r].link == link) begin
				f.tail    = 1'b0;
				f.payload = pkt_table[r].route; // header, dropped by the deserializer
				push_flit(link, f);
				for (int g = 0; g < pkt_table[r].groups; g++) begin
					for (int s = 0; s < 3; s++) begin
						f.tail    = (g == pkt_table[r].groups - 1) && (s == 2); // last flit only
						f.payload = pkt_table[r].pay[g][(2 - s) * FLIT_PAYLOAD_W +: FLIT_PAYLOAD_W];
						push_flit(link, f);
						if (s == 2) groups_pushed++;
					end
				end
			end
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		clk        = 1'b0;
		reset      = 1'b0;
		north_flit = '0;
		east_flit  = '0;
		north_push = 1'b0;
		east_push  = 1'b0;
		core_ack   = 1'b0;

		add_packet(link_north, 1, 10'h3a5, 30'h0abcdef1, 30'h0, 30'h0);
		add_packet(link_east,  2, 10'h15a, 30'h3fffffff, 30'h00000001, 30'h0);
		add_packet(link_north, 3, 10'h2c3, 30'h11223344, 30'h25566778, 30'h099aabbc);
		add_packet(link_east,  1, 10'h0f0, 30'h2468ace0, 30'h0, 30'h0);
		add_packet(link_north, 2, 10'h3ff, 30'h13579bdf, 30'h3c3c3c3c, 30'h0);
		add_packet(link_east,  3, 10'h001, 30'h30000000, 30'h00aa55aa, 30'h1fedcba9);
		add_packet(link_north, 3, 10'h2aa, 30'h05a5a5a5, 30'h3a5a5a5a, 30'h00000000);
		add_packet(link_east,  3, 10'h155, 30'h12481248, 30'h3ffffc00, 30'h000003ff);
		cycle_limit = 50 * total_flits + 200;

		repeat (8) @(posedge clk); // reset low for 8 cycles
		#2;
		reset = 1'b1;

		// every expected word consumed by the scoreboard
		while (north_exp.size() != 0 || east_exp.size() != 0) @(posedge clk);
		repeat (20) @(posedge clk);
		#2;
		check_equal(core_valid, 1'b0, "extra word after the last expected one");
		check_equal(saw_north_full, 1'b1, "north full never rose during stall");
		check_equal(saw_east_full, 1'b1, "east full never rose during stall");
		check_equal(have_held, 1'b1, "no word held during stall");
		$display(">>> PASS");
		$finish;
	end

	initial begin : north_driver
		wait (reset === 1'b1);
		@(posedge clk);
		#2;
		drive_link(link_north);
	end

	initial begin : east_driver
		wait (reset === 1'b1);
		@(posedge clk);
		#2;
		drive_link(link_east);
	end

	//////////////////////////////
	// core side acknowledge
	//////////////////////////////

	initial begin : core_ack_gen
		core_msg_t held;
		logic      stall_done;
		stall_done = 1'b0;
		wait (reset === 1'b1);
		@(posedge clk);
		#2;
		forever begin
			if (acks_done >= 2 && !stall_done) begin
				core_ack = 1'b0; // back-pressure, 40 cycles
				for (int i = 0; i < 40; i++) begin
					@(posedge clk);
					#2;
					if (core_valid && !have_held) begin
						held      = core_msg;
						have_held = 1'b1;
					end else if (core_valid) begin
						check_equal(core_msg, held, "core_msg moved while core_ack low");
					end
				end
				stall_done = 1'b1;
			end
			core_ack = ($random(seed) & 3) != 0; // ack about 3 cycles in 4
			@(posedge clk);
			#2;
		end
	end

	//////////////////////////////
	// scoreboard and timeout
	//////////////////////////////

	always @(negedge clk) begin : scoreboard
		core_word_t exp;
		if (reset === 1'b1 && groups_pushed == 0) begin
			check_equal(core_valid, 1'b0, "core_valid before first group");
		end
		if (north_full) saw_north_full = 1'b1;
		if (east_full)  saw_east_full  = 1'b1;
		if (reset === 1'b1 && core_valid && core_ack) begin // handshake on the next edge
			check_equal(core_msg.word.zero, 2'b00, "zero field of core word");
			if (core_msg.src == link_north && north_exp.size() == 0) begin
				$display("unexpected word from the north link, nothing left to receive");
				$display(">>> FAIL");
				$fatal(1);
			end else if (core_msg.src == link_east && east_exp.size() == 0) begin
				$display("unexpected word from the east link, nothing left to receive");
				$display(">>> FAIL");
				$fatal(1);
			end else begin
				exp = (core_msg.src == link_north) ? north_exp.pop_front() : east_exp.pop_front();
				check_equal(core_msg.word, exp, "core word in link order");
				acks_done++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, words still missing", cycle_count);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

endmodule

// File: hdl/ni_rx.sv
`timescale 1ns/1ps

// receive side of the network interface
//   north link -> buffer -> deserializer --\
//                                           arbiter -> core
//   east link  -> buffer -> deserializer --/
module ni_rx import noc_rx_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  flit_t     north_flit,
	input  flit_t     east_flit,
	input  logic      north_push,
	input  logic      east_push,
	output logic      north_full, // link must hold off while high
	output logic      east_full,
	output core_msg_t core_msg,
	output logic      core_valid,
	input  logic      core_ack
);

	//////////////////////////////
	// north lane
	//////////////////////////////

	flit_t      north_head;
	logic       north_empty;
	logic       north_pop;
	core_word_t north_word;
	logic       north_word_valid;
	logic       north_taken;

	flit_fifo #(.DEPTH(1 << FIFO_AW)) north_fifo (
		.clk   (clk),
		.reset (reset),
		.flit  (north_flit),
		.push  (north_push),
		.pop   (north_pop),
		.head  (north_head),
		.empty (north_empty),
		.full  (north_full)
	);

	flit_deserializer north_deser (
		.clk        (clk),
		.reset      (reset),
		.head       (north_head),
		.empty      (north_empty),
		.pop        (north_pop),
		.word       (north_word),
		.word_valid (north_word_valid),
		.word_taken (north_taken)
	);

	//////////////////////////////
	// east lane
	//////////////////////////////

	flit_t      east_head;
	logic       east_empty;
	logic       east_pop;
	core_word_t east_word;
	logic       east_word_valid;
	logic       east_taken;

	flit_fifo #(.DEPTH(1 << FIFO_AW)) east_fifo (
		.clk   (clk),
		.reset (reset),
		.flit  (east_flit),
		.push  (east_push),
		.pop   (east_pop),
		.head  (east_head),
		.empty (east_empty),
		.full  (east_full)
	);

	flit_deserializer east_deser (
		.clk        (clk),
		.reset      (reset),
		.head       (east_head),
		.empty      (east_empty),
		.pop        (east_pop),
		.word       (east_word),
		.word_valid (east_word_valid),
		.word_taken (east_taken)
	);

	//////////////////////////////
	// merge onto the core channel
	//////////////////////////////

	word_arbiter word_arbiter (
		.clk         (clk),
		.reset       (reset),
		.north_word  (north_word),
		.east_word   (east_word),
		.north_valid (north_word_valid),
		.east_valid  (east_word_valid),
		.north_taken (north_taken),
		.east_taken  (east_taken),
		.core_msg    (core_msg),
		.core_valid  (core_valid),
		.core_ack    (core_ack)
	);

endmodule

// File: hdl/word_arbiter.sv
`timescale 1ns/1ps

// merges north and east words into the single core channel
// one-word output register, round robin when both lanes wait
module word_arbiter import noc_rx_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  core_word_t north_word,
	input  core_word_t east_word,
	input  logic       north_valid,
	input  logic       east_valid,
	output logic       north_taken, // one-cycle pulse back to the lane
	output logic       east_taken,
	output core_msg_t  core_msg,
	output logic       core_valid,
	input  logic       core_ack     // one-cycle pulse from the core
);

	core_msg_t msg_q;   // output register
	logic      valid_q;
	link_id_t  last_q;  // lane served most recently
	link_id_t  pick;    // lane chosen this cycle
	logic      load;

	//////////////////////////////
	// lane selection
	//////////////////////////////

	// only load into an empty register, the cycle after ack at the earliest
	assign load = !valid_q && (north_valid || east_valid);

	always_comb begin
		if (north_valid && east_valid) begin
			pick = (last_q == link_north) ? link_east : link_north; // other one's turn
		end else if (east_valid) begin
			pick = link_east;
		end else begin
			pick = link_north; // north only, or nothing (load is low then)
		end
	end

	assign north_taken = load && (pick == link_north);
	assign east_taken  = load && (pick == link_east);

	//////////////////////////////
	// output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (load) begin
			msg_q.src  <= pick;
			msg_q.word <= (pick == link_east) ? east_word : north_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_q <= 1'b0;
			last_q  <= link_east; // north gets the first tie
		end else if (load) begin
			valid_q <= 1'b1;
			last_q  <= pick;
		end else if (core_ack) begin
			valid_q <= 1'b0; // ack only means something while holding
		end
	end

	assign core_msg   = msg_q;
	assign core_valid = valid_q;

	//////////////////////////////
	// checks
	//////////////////////////////

	a_one_taken: assert property (@(posedge clk) disable iff (!reset)
		$onehot0({north_taken, east_taken}))
		else $error("word_arbiter: both lanes taken in one cycle");

	// core must see a steady word until it acks
	a_hold_until_ack: assert property (@(posedge clk) disable iff (!reset)
		core_valid && !core_ack |=> core_valid && $stable(core_msg))
		else $error("word_arbiter: core_msg changed before core_ack");

endmodule

// File: hdl/flit_deserializer.sv
`timescale 1ns/1ps

// turns the flit stream of one link into core words
//   header flit  -> dropped (route only)
//   3 data flits -> one word, slices hi/mid/lo = payload 29..20 / 19..10 / 9..0
//   tail on the lo flit ends the packet, otherwise another group follows
module flit_deserializer import noc_rx_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  flit_t      head,       // show-ahead output of the link buffer
	input  logic       empty,
	output logic       pop,
	output core_word_t word,
	output logic       word_valid,
	input  logic       word_taken  // one-cycle pulse from the arbiter
);

	localparam int PAYLOAD_W = 3 * FLIT_PAYLOAD_W; // 30 bits per group

	deser_state_t state;
	deser_state_t next_state;

	logic [PAYLOAD_W-1:0] payload_q; // code + data
	logic                 in_flit;   // in a state that consumes flits
	logic                 last_flit; // popping the lo flit this cycle

	//////////////////////////////
	// flit consumption
	//////////////////////////////

	// header and the three data slices all get popped the same way,
	// only the hold states leave the buffer alone
	assign in_flit = (state == wait_header) || (state == flit_hi) ||
	                 (state == flit_mid) || (state == flit_lo);

	assign pop       = in_flit && !empty;
	assign last_flit = (state == flit_lo) && !empty;

	always_comb begin
		next_state = state; // stay put by default (buffer empty or word not taken)
		case (state)
			wait_header: if (!empty) next_state = flit_hi;  // drop the route flit
			flit_hi:     if (!empty) next_state = flit_mid;
			flit_mid:    if (!empty) next_state = flit_lo;
			flit_lo: begin
				if (!empty) begin
					// tail only counts on the last flit of a group
					next_state = head.tail ? hold_last : hold_more;
				end
			end
			hold_last:   if (word_taken) next_state = wait_header; // next flit is a header
			hold_more:   if (word_taken) next_state = flit_hi;     // straight into next group
			default:     next_state = wait_header;                 // unused encodings
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= wait_header;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////
	// word assembly
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!empty) begin
			case (state)
				flit_hi:  payload_q[2*FLIT_PAYLOAD_W +: FLIT_PAYLOAD_W] <= head.payload;
				flit_mid: payload_q[FLIT_PAYLOAD_W +: FLIT_PAYLOAD_W]   <= head.payload;
				flit_lo:  payload_q[0 +: FLIT_PAYLOAD_W]                <= head.payload;
				default:  payload_q <= payload_q; // header or holding
			endcase
		end
	end

	// zero extension fills the two unused top bits
	assign word = core_word_t'(CORE_WORD_W'(payload_q));

	// valid set by the lo pop and cleared by taken
	always_ff @(posedge clk) begin
		if (!reset) begin
			word_valid <= 1'b0;
		end else if (last_flit) begin
			word_valid <= 1'b1;
		end else if (word_taken) begin
			word_valid <= 1'b0;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_pop_not_empty: assert property (@(posedge clk) disable iff (!reset)
		pop |-> !empty)
		else $error("flit_deserializer: pop on empty buffer");

	// valid flop and state must agree, a word is never offered mid-group
	a_no_valid_in_flit: assert property (@(posedge clk) disable iff (!reset)
		(state inside {flit_hi, flit_mid, flit_lo}) |-> !word_valid)
		else $error("flit_deserializer: word_valid high while collecting flits");

	// arbiter should only take what is offered
	a_taken_when_valid: assert property (@(posedge clk) disable iff (!reset)
		word_taken |-> word_valid)
		else $error("flit_deserializer: word_taken without word_valid");

endmodule

// File: hdl/flit_fifo.sv
`timescale 1ns/1ps

// show-ahead flit buffer, one per router link
// head is the oldest flit and is valid whenever empty is low
module flit_fifo import noc_rx_pkg::*; #(
	parameter int DEPTH = FIFO_DEPTH // keep this a power of two, pointers wrap on overflow
) (
	input  logic  clk,
	input  logic  reset,
	input  flit_t flit,  // from the router link
	input  logic  push,  // write strobe from the link
	input  logic  pop,   // read strobe from the deserializer
	output flit_t head,  // oldest flit, combinational from rd_ptr
	output logic  empty,
	output logic  full
);

	localparam int AW = $clog2(DEPTH);

	//////////////////////////////
	// storage and pointers
	//////////////////////////////

	flit_t         mem [DEPTH]; // payload storage
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;       // one extra bit so DEPTH fits

	logic do_push;
	logic do_pop;

	assign do_push = push && !full;  // a push on full is dropped (and flagged below)
	assign do_pop  = pop && !empty;

	assign full  = (count == DEPTH[AW:0]);
	assign empty = (count == '0);
	assign head  = mem[rd_ptr]; // show-ahead

	// write side
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= flit;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or both at once
			endcase
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// there are no credits back to the router, so the link must watch full itself
	a_no_push_full: assert property (@(posedge clk) disable iff (!reset)
		push |-> !full)
		else $error("flit_fifo: push while full, flit lost");

	// deserializer must only read what is there
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset)
		pop |-> !empty)
		else $error("flit_fifo: pop while empty");

endmodule

// File: hdl/noc_rx_pkg.sv
// shared types for the noc receive path (router flits in, core words out)
package noc_rx_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	localparam int FLIT_PAYLOAD_W = 10;                 // data bits per flit
	localparam int CORE_WORD_W    = 32;                 // word handed to the core
	localparam int FIFO_DEPTH     = 8;                  // default flits per link buffer
	localparam int FIFO_AW        = $clog2(FIFO_DEPTH); // buffer pointer width

	//////////////////////////////
	// router side
	//////////////////////////////

	// flit as it arrives on a link
	//   [10]   tail, only meaningful on the last flit of a group
	//   [9:0]  route (header flit) or data slice
	typedef struct packed {
		logic                      tail;
		logic [FLIT_PAYLOAD_W-1:0] payload;
	} flit_t;

	// which router link a word came in on
	typedef enum logic [0:0] {
		link_north = 1'b0,
		link_east  = 1'b1
	} link_id_t;

	//////////////////////////////
	// core side
	//////////////////////////////

	// one group of three flits becomes one of these
	// top two bits never carry anything
	typedef struct packed {
		logic [1:0]  zero; // always 2'b00
		logic [5:0]  code; // passed through, nobody decodes it here
		logic [23:0] data;
	} core_word_t;

	// what the core actually sees: word plus the link it arrived on
	typedef struct packed {
		link_id_t   src;
		core_word_t word;
	} core_msg_t;

	//////////////////////////////
	// deserializer fsm
	//////////////////////////////

	typedef enum logic [2:0] {
		wait_header = 3'd0, // next flit is a header, drop it
		flit_hi     = 3'd1, // payload bits 29..20
		flit_mid    = 3'd2, // payload bits 19..10
		flit_lo     = 3'd3, // payload bits 9..0, tail sampled here
		hold_last   = 3'd4, // word out, packet finished
		hold_more   = 3'd5  // word out, another group follows
	} deser_state_t;

endpackage
